//--- common/cache_mem_pkg.sv
////////////////////
// Shared widths, source numbering and bus structs of the L1 memory plumbing.
// Modules refer to these by scoped names, no import.
////////////////////
package cache_mem_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int ADDR_WIDTH = 40;  // Physical address
  localparam int DATA_WIDTH = 64;
  localparam int BE_WIDTH   = DATA_WIDTH / 8;

  ////////////////////
  // Sources
  ////////////////////
  localparam int NUM_SOURCES = 4;
  localparam int SRC_WIDTH   = 2;
  localparam int SEQ_WIDTH   = 3;  // Per-source sequence number

  localparam int SRC_ICACHE_MISS = 0;
  localparam int SRC_DCACHE_MISS = 1;
  localparam int SRC_WBUF_WRITE  = 2;
  localparam int SRC_UC_WRITE    = 3;

  typedef logic [SRC_WIDTH-1:0] src_id_t;

  // Transaction ID carried on the memory port
  typedef struct packed {
    src_id_t              src;
    logic [SEQ_WIDTH-1:0] seq;
  } mem_id_t;

  // Request as presented by a source
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  is_write;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
  } src_req_t;

  // Request on the memory port, write data folded into the same word
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  is_write;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
    mem_id_t               id;
  } mem_req_t;

  typedef struct packed {
    mem_id_t               id;
    logic                  is_write;
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  // Response as seen by a source, source field already stripped
  typedef struct packed {
    logic                  is_write;
    logic [DATA_WIDTH-1:0] rdata;
    logic [SEQ_WIDTH-1:0]  seq;
  } src_rsp_t;

endpackage

//--- mem_arbiter/mem_req_arbiter.sv
////////////////////
// Round-robin arbiter of the four source request channels onto the memory
// request port. The grant is locked while the memory side stalls.
////////////////////
`timescale 1ns/1ns

module mem_req_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Source request channels
  input  logic     [cache_mem_pkg::NUM_SOURCES-1:0]     src_req_valid_i,
  output logic     [cache_mem_pkg::NUM_SOURCES-1:0]     src_req_ready_o,
  input  cache_mem_pkg::src_req_t [cache_mem_pkg::NUM_SOURCES-1:0] src_req_i,
  // From the transaction tracker
  input  logic     [cache_mem_pkg::NUM_SOURCES-1:0]     src_block_i,
  input  logic     [cache_mem_pkg::NUM_SOURCES-1:0][cache_mem_pkg::SEQ_WIDTH-1:0] src_seq_i,
  // Memory request port
  output logic                                          mem_req_valid_o,
  input  logic                                          mem_req_ready_i,
  output cache_mem_pkg::mem_req_t                       mem_req_o,
  // To the transaction tracker
  output logic                                          req_fire_o,
  output cache_mem_pkg::src_id_t                        req_src_o
);

  logic [cache_mem_pkg::NUM_SOURCES-1:0] eligible;
  cache_mem_pkg::src_id_t                rr_ptr_q;
  cache_mem_pkg::src_id_t                pick_src;
  cache_mem_pkg::src_id_t                grant_src;
  logic                                  lock_q;
  cache_mem_pkg::src_id_t                lock_src_q;
  logic                                  stall;

  assign eligible = src_req_valid_i & ~src_block_i;  // Full sources wait

  ////////////////////
  // Source selection
  ////////////////////

  // First eligible source at or after the pointer
  always_comb begin : pick_first
    int  idx;
    logic found;
    found    = 1'b0;
    pick_src = rr_ptr_q;
    for (int i = 0; i < cache_mem_pkg::NUM_SOURCES; i++) begin
      idx = (int'(rr_ptr_q) + i) % cache_mem_pkg::NUM_SOURCES;
      if (!found && eligible[idx]) begin
        found    = 1'b1;
        pick_src = cache_mem_pkg::src_id_t'(idx);
      end
    end
  end

  assign grant_src       = lock_q ? lock_src_q : pick_src;  // Held grant wins
  assign mem_req_valid_o = lock_q | (|eligible);
  assign stall           = mem_req_valid_o & ~mem_req_ready_i;

  assign req_fire_o = mem_req_valid_o & mem_req_ready_i;
  assign req_src_o  = grant_src;

  // Ready only towards the granted source
  always_comb begin
    src_req_ready_o            = '0;
    src_req_ready_o[grant_src] = req_fire_o;
  end

  ////////////////////
  // Request word
  ////////////////////
  always_comb begin
    mem_req_o.addr     = src_req_i[grant_src].addr;
    mem_req_o.is_write = src_req_i[grant_src].is_write;
    mem_req_o.wdata    = src_req_i[grant_src].wdata;
    mem_req_o.be       = src_req_i[grant_src].be;
    mem_req_o.id.src   = grant_src;
    mem_req_o.id.seq   = src_seq_i[grant_src];  // Only moves on this source's transfer
  end

  ////////////////////
  // Grant lock and pointer
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      lock_src_q <= '0;
      rr_ptr_q   <= '0;
    end else begin
      lock_q <= stall;
      if (stall) begin
        lock_src_q <= grant_src;
      end
      // Move past the winner on every transfer
      if (req_fire_o) begin
        rr_ptr_q <= cache_mem_pkg::src_id_t'(
          (int'(grant_src) + 1) % cache_mem_pkg::NUM_SOURCES);
      end
    end
  end

endmodule

//--- mem_arbiter/mem_txn_tracker.sv
////////////////////
// Per-source in-flight counters and sequence numbers.
// Supplies the ID sequence field and blocks sources that are full.
////////////////////
`timescale 1ns/1ns

module mem_txn_tracker #(
  parameter int MaxOutstanding = 4  // At most 2**SEQ_WIDTH
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Request transfers from the arbiter
  input  logic                                   req_fire_i,
  input  cache_mem_pkg::src_id_t                 req_src_i,
  // Responses from the router
  input  logic                                   rsp_fire_i,
  input  cache_mem_pkg::src_id_t                 rsp_src_i,
  // Per-source status
  output logic [cache_mem_pkg::NUM_SOURCES-1:0]  src_block_o,
  output logic [cache_mem_pkg::NUM_SOURCES-1:0][cache_mem_pkg::SEQ_WIDTH-1:0] src_seq_o
);

  localparam int CntWidth = $clog2(MaxOutstanding + 1);

  logic [cache_mem_pkg::NUM_SOURCES-1:0][CntWidth-1:0]                 cnt_q;
  logic [cache_mem_pkg::NUM_SOURCES-1:0][cache_mem_pkg::SEQ_WIDTH-1:0] seq_q;
  logic [cache_mem_pkg::NUM_SOURCES-1:0]                               inc;
  logic [cache_mem_pkg::NUM_SOURCES-1:0]                               dec;

  for (genvar s = 0; s < cache_mem_pkg::NUM_SOURCES; s++) begin : gen_src

    assign inc[s] = req_fire_i && (req_src_i == cache_mem_pkg::src_id_t'(s));
    // Stray response on an empty source must not wrap the count
    assign dec[s] = rsp_fire_i && (rsp_src_i == cache_mem_pkg::src_id_t'(s))
                    && (cnt_q[s] != '0);

    ////////////////////
    // In-flight count
    ////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[s] <= '0;
      end else if (inc[s] != dec[s]) begin
        if (inc[s]) begin
          cnt_q[s] <= cnt_q[s] + CntWidth'(1);
        end else begin
          cnt_q[s] <= cnt_q[s] - CntWidth'(1);
        end
      end
    end

    // Sequence number, wraps at 2**SEQ_WIDTH
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        seq_q[s] <= '0;
      end else if (inc[s]) begin
        seq_q[s] <= seq_q[s] + cache_mem_pkg::SEQ_WIDTH'(1);
      end
    end

    assign src_block_o[s] = (cnt_q[s] == CntWidth'(MaxOutstanding));
    assign src_seq_o[s]   = seq_q[s];

  end

endmodule

//--- mem_arbiter/mem_rsp_router.sv
////////////////////
// Routes memory responses back to their source by the ID source field.
// One register stage, one response per cycle.
////////////////////
`timescale 1ns/1ns

module mem_rsp_router (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Memory response port
  input  logic                                  mem_rsp_valid_i,
  input  cache_mem_pkg::mem_rsp_t               mem_rsp_i,
  // To the transaction tracker
  output logic                                  rsp_fire_o,
  output cache_mem_pkg::src_id_t                rsp_src_o,
  // Source responses, no backpressure
  output logic [cache_mem_pkg::NUM_SOURCES-1:0] src_rsp_valid_o,
  output cache_mem_pkg::src_rsp_t [cache_mem_pkg::NUM_SOURCES-1:0] src_rsp_o
);

  logic [cache_mem_pkg::NUM_SOURCES-1:0] hit;  // Decoded source

  assign rsp_fire_o = mem_rsp_valid_i;
  assign rsp_src_o  = mem_rsp_i.id.src;

  for (genvar s = 0; s < cache_mem_pkg::NUM_SOURCES; s++) begin : gen_slot

    assign hit[s] = mem_rsp_valid_i && (mem_rsp_i.id.src == cache_mem_pkg::src_id_t'(s));

    // Valid lasts one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        src_rsp_valid_o[s] <= 1'b0;
      end else begin
        src_rsp_valid_o[s] <= hit[s];
      end
    end

    ////////////////////
    // Payload slot
    ////////////////////
    always_ff @(posedge clk_i) begin
      if (hit[s]) begin
        src_rsp_o[s].is_write <= mem_rsp_i.is_write;
        src_rsp_o[s].rdata    <= mem_rsp_i.rdata;
        src_rsp_o[s].seq      <= mem_rsp_i.id.seq;
      end
    end

  end

endmodule

//--- verilog/cache_mem_subsystem.sv
////////////////////
// Memory plumbing of the L1 cache subsystem: four miss and write sources
// share one memory port. Also returns the data-cache flush acknowledge.
////////////////////
`timescale 1ns/1ns

module cache_mem_subsystem #(
  parameter int MaxOutstanding = 4  // In-flight limit per source
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Source request channels
  input  logic [cache_mem_pkg::NUM_SOURCES-1:0] src_req_valid_i,
  output logic [cache_mem_pkg::NUM_SOURCES-1:0] src_req_ready_o,
  input  cache_mem_pkg::src_req_t [cache_mem_pkg::NUM_SOURCES-1:0] src_req_i,
  // Source responses
  output logic [cache_mem_pkg::NUM_SOURCES-1:0] src_rsp_valid_o,
  output cache_mem_pkg::src_rsp_t [cache_mem_pkg::NUM_SOURCES-1:0] src_rsp_o,
  // Memory request port
  output logic                                  mem_req_valid_o,
  input  logic                                  mem_req_ready_i,
  output cache_mem_pkg::mem_req_t               mem_req_o,
  // Memory response port
  input  logic                                  mem_rsp_valid_i,
  input  cache_mem_pkg::mem_rsp_t               mem_rsp_i,
  // Data-cache flush
  input  logic                                  dcache_flush_i,
  output logic                                  dcache_flush_ack_o
);

  logic [cache_mem_pkg::NUM_SOURCES-1:0]                               src_block;
  logic [cache_mem_pkg::NUM_SOURCES-1:0][cache_mem_pkg::SEQ_WIDTH-1:0] src_seq;
  logic                                                                req_fire;
  cache_mem_pkg::src_id_t                                              req_src;
  logic                                                                rsp_fire;
  cache_mem_pkg::src_id_t                                              rsp_src;

  ////////////////////
  // Request path
  ////////////////////
  mem_req_arbiter i_mem_req_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .src_req_valid_i (src_req_valid_i),
    .src_req_ready_o (src_req_ready_o),
    .src_req_i       (src_req_i),
    .src_block_i     (src_block),
    .src_seq_i       (src_seq),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .req_fire_o      (req_fire),
    .req_src_o       (req_src)
  );

  mem_txn_tracker #(
    .MaxOutstanding (MaxOutstanding)
  ) i_mem_txn_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_fire_i  (req_fire),
    .req_src_i   (req_src),
    .rsp_fire_i  (rsp_fire),
    .rsp_src_i   (rsp_src),
    .src_block_o (src_block),
    .src_seq_o   (src_seq)
  );

  // Response path
  mem_rsp_router i_mem_rsp_router (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i),
    .rsp_fire_o      (rsp_fire),
    .rsp_src_o       (rsp_src),
    .src_rsp_valid_o (src_rsp_valid_o),
    .src_rsp_o       (src_rsp_o)
  );

  // Single-cycle ack, alternates while the request stays high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dcache_flush_ack_o <= 1'b0;
    end else begin
      dcache_flush_ack_o <= dcache_flush_i & ~dcache_flush_ack_o;
    end
  end

endmodule

//--- testbench/cache_mem_subsystem_asserts.sv
////////////////////
// Port-level checks of the cache memory subsystem: stall stability, response
// routing, in-flight limit, sequence numbers, fairness and flush acknowledge.
////////////////////
`timescale 1ns/1ns

module cache_mem_subsystem_asserts (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic [cache_mem_pkg::NUM_SOURCES-1:0] src_req_valid_i,
  input logic [cache_mem_pkg::NUM_SOURCES-1:0] src_rsp_valid_o,
  input cache_mem_pkg::src_rsp_t [cache_mem_pkg::NUM_SOURCES-1:0] src_rsp_o,
  input logic                                  mem_req_valid_o,
  input logic                                  mem_req_ready_i,
  input cache_mem_pkg::mem_req_t               mem_req_o,
  input logic                                  mem_rsp_valid_i,
  input cache_mem_pkg::mem_rsp_t               mem_rsp_i,
  input logic                                  dcache_flush_i,
  input logic                                  dcache_flush_ack_o
);

  logic [cache_mem_pkg::NUM_SOURCES-1:0][2:0]                          cnt_q;  // 0 to 4
  logic [cache_mem_pkg::NUM_SOURCES-1:0][cache_mem_pkg::SEQ_WIDTH-1:0] seq_q;
  logic [cache_mem_pkg::NUM_SOURCES-1:0] inc;
  logic [cache_mem_pkg::NUM_SOURCES-1:0] dec;
  logic [cache_mem_pkg::NUM_SOURCES-1:0] exp_valid;
  cache_mem_pkg::src_id_t                rr_q;  // Expected round-robin winner
  logic                                  rsp_valid_q;
  cache_mem_pkg::mem_rsp_t               rsp_q;
  cache_mem_pkg::src_rsp_t               exp_rsp;
  logic                                  req_fire;
  cache_mem_pkg::src_id_t                fire_src;
  logic                                  all_free;

  assign req_fire = mem_req_valid_o & mem_req_ready_i;
  assign fire_src = mem_req_o.id.src;

  always_comb begin
    all_free = 1'b1;
    for (int s = 0; s < cache_mem_pkg::NUM_SOURCES; s++) begin
      inc[s] = req_fire && (fire_src == cache_mem_pkg::src_id_t'(s));
      dec[s] = mem_rsp_valid_i && (mem_rsp_i.id.src == cache_mem_pkg::src_id_t'(s))
               && (cnt_q[s] != 3'd0);
      if (cnt_q[s] == 3'd4) begin
        all_free = 1'b0;
      end
    end
    exp_valid                  = '0;
    exp_valid[rsp_q.id.src]    = rsp_valid_q;
    exp_rsp.is_write           = rsp_q.is_write;
    exp_rsp.rdata              = rsp_q.rdata;
    exp_rsp.seq                = rsp_q.id.seq;
  end

  ////////////////////
  // Reference state
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q       <= '0;
      seq_q       <= '0;
      rr_q        <= '0;
      rsp_valid_q <= 1'b0;
      rsp_q       <= '0;
    end else begin
      for (int s = 0; s < cache_mem_pkg::NUM_SOURCES; s++) begin
        cnt_q[s] <= cnt_q[s] + 3'(inc[s]) - 3'(dec[s]);
        if (inc[s]) begin
          seq_q[s] <= seq_q[s] + cache_mem_pkg::SEQ_WIDTH'(1);
        end
      end
      if (req_fire) begin
        rr_q <= fire_src + cache_mem_pkg::src_id_t'(1);  // Wraps at four sources
      end
      rsp_valid_q <= mem_rsp_valid_i;
      rsp_q       <= mem_rsp_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
  else begin
    $error("Memory request dropped or changed while stalled");
    tb_cache_mem_subsystem.assert_errors++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (src_rsp_valid_o == exp_valid) && (!rsp_valid_q || src_rsp_o[rsp_q.id.src] == exp_rsp))
  else begin
    $error("Response routed to the wrong source or with a wrong payload");
    tb_cache_mem_subsystem.assert_errors++;
  end

  // Limit of four in flight, sequence steps by one
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_fire |-> (cnt_q[fire_src] < 3'd4) && (mem_req_o.id.seq == seq_q[fire_src]))
  else begin
    $error("In-flight limit exceeded or sequence number skipped");
    tb_cache_mem_subsystem.assert_errors++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_fire && (&src_req_valid_i) && all_free && $past(mem_req_ready_i)
    |-> fire_src == rr_q)
  else begin
    $error("Round-robin order broken with all sources requesting");
    tb_cache_mem_subsystem.assert_errors++;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_flush_ack_o |-> $past(dcache_flush_i) && !$past(dcache_flush_ack_o))
  else begin
    $error("Flush acknowledge held too long or raised without a flush");
    tb_cache_mem_subsystem.assert_errors++;
  end

  // A pending flush with the ack low is answered in the next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_flush_i && !dcache_flush_ack_o |=> dcache_flush_ack_o)
  else begin
    $error("Flush acknowledge missing after a flush request");
    tb_cache_mem_subsystem.assert_errors++;
  end

endmodule

//--- testbench/tb_cache_mem_subsystem.sv
////////////////////
// Testbench of the cache memory subsystem. Random source traffic against a
// memory responder with random delays, then all sources held valid.
////////////////////
`timescale 1ns/1ns

module tb_cache_mem_subsystem;

  localparam int Phase1Reqs     = 24;  // Per source, random gaps
  localparam int Phase2Reqs     = 16;  // Per source, held valid
  localparam int MaxDelay       = 8;
  localparam int NumSrc         = cache_mem_pkg::NUM_SOURCES;
  localparam int TotalReqs      = NumSrc * (Phase1Reqs + Phase2Reqs);
  localparam int WatchdogCycles = 20 * TotalReqs * MaxDelay;
  localparam logic [cache_mem_pkg::DATA_WIDTH-1:0] ReadMask = 64'h5a5a_5a5a_5a5a_5a5a;

  typedef struct packed {
    cache_mem_pkg::mem_rsp_t rsp;
    logic [31:0]             due;  // Cycle of the answer
  } pend_t;

  logic                                         clk_i;
  logic                                         rst_ni;
  logic [NumSrc-1:0]                            src_req_valid_i;
  logic [NumSrc-1:0]                            src_req_ready_o;
  cache_mem_pkg::src_req_t [NumSrc-1:0]         src_req_i;
  logic [NumSrc-1:0]                            src_rsp_valid_o;
  cache_mem_pkg::src_rsp_t [NumSrc-1:0]         src_rsp_o;
  logic                                         mem_req_valid_o;
  logic                                         mem_req_ready_i;
  cache_mem_pkg::mem_req_t                      mem_req_o;
  logic                                         mem_rsp_valid_i;
  cache_mem_pkg::mem_rsp_t                      mem_rsp_i;
  logic                                         dcache_flush_i;
  logic                                         dcache_flush_ack_o;

  int                                           assert_errors;  // Bumped by the checker
  int                                           check_errors;
  integer                                       seed;
  int                                           cycle;
  int                                           delay;
  logic                                         hold_valid;
  logic                                         ready_always;
  logic [NumSrc-1:0]                            fired;
  int                                           quota [NumSrc];
  int                                           issued [NumSrc];
  int                                           sent [NumSrc];
  int                                           in_flight [NumSrc];
  logic [cache_mem_pkg::SEQ_WIDTH-1:0]          tb_seq [NumSrc];
  logic [cache_mem_pkg::ADDR_WIDTH-1:0]         exp_addr [NumSrc][2**cache_mem_pkg::SEQ_WIDTH];
  logic                                         exp_write [NumSrc][2**cache_mem_pkg::SEQ_WIDTH];
  pend_t                                        pend_q [$];
  pend_t                                        entry;
  logic [63:0]                                  rnd;

  cache_mem_subsystem #(
    .MaxOutstanding (4)
  ) i_cache_mem_subsystem (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .src_req_valid_i    (src_req_valid_i),
    .src_req_ready_o    (src_req_ready_o),
    .src_req_i          (src_req_i),
    .src_rsp_valid_o    (src_rsp_valid_o),
    .src_rsp_o          (src_rsp_o),
    .mem_req_valid_o    (mem_req_valid_o),
    .mem_req_ready_i    (mem_req_ready_i),
    .mem_req_o          (mem_req_o),
    .mem_rsp_valid_i    (mem_rsp_valid_i),
    .mem_rsp_i          (mem_rsp_i),
    .dcache_flush_i     (dcache_flush_i),
    .dcache_flush_ack_o (dcache_flush_ack_o)
  );

  bind cache_mem_subsystem cache_mem_subsystem_asserts i_cache_mem_subsystem_asserts (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Memory model data for reads
  function automatic logic [cache_mem_pkg::DATA_WIDTH-1:0] read_pattern(
    input logic [cache_mem_pkg::ADDR_WIDTH-1:0] addr
  );
    logic [cache_mem_pkg::DATA_WIDTH-1:0] word;
    word                                 = '0;
    word[cache_mem_pkg::ADDR_WIDTH-1:0] = addr;
    return word ^ ReadMask;
  endfunction

  function automatic logic traffic_done();
    logic done;
    done = (pend_q.size() == 0) && !mem_rsp_valid_i;
    for (int s = 0; s < NumSrc; s++) begin
      if (sent[s] != quota[s]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic new_request(input int s);
    rnd                   = {$random(seed), $random(seed)};
    src_req_i[s].addr     = {rnd[cache_mem_pkg::ADDR_WIDTH-1:3], 3'b000};  // Word aligned
    src_req_i[s].is_write = (s == cache_mem_pkg::SRC_WBUF_WRITE)
                            || (s == cache_mem_pkg::SRC_UC_WRITE);
    src_req_i[s].wdata    = {$random(seed), $random(seed)};
    src_req_i[s].be       = (s == cache_mem_pkg::SRC_UC_WRITE) ? rnd[63:56] : '1;
    src_req_valid_i[s]    = 1'b1;
    issued[s]++;
  endtask

  // Memory port word against the request of the source that got ready
  task automatic check_request(input int s);
    if (mem_req_o.id.src !== cache_mem_pkg::src_id_t'(s)) begin
      $display("CHECK FAILED mem_req_o.id.src exp %h got %h", cache_mem_pkg::src_id_t'(s),
               mem_req_o.id.src);
      check_errors++;
    end
    if (mem_req_o.addr !== src_req_i[s].addr) begin
      $display("CHECK FAILED mem_req_o.addr exp %h got %h", src_req_i[s].addr,
               mem_req_o.addr);
      check_errors++;
    end
    if (mem_req_o.wdata !== src_req_i[s].wdata) begin
      $display("CHECK FAILED mem_req_o.wdata exp %h got %h", src_req_i[s].wdata,
               mem_req_o.wdata);
      check_errors++;
    end
    if (mem_req_o.be !== src_req_i[s].be) begin
      $display("CHECK FAILED mem_req_o.be exp %h got %h", src_req_i[s].be, mem_req_o.be);
      check_errors++;
    end
  endtask

  task automatic check_response(input int s);
    logic [cache_mem_pkg::SEQ_WIDTH-1:0]  seq;
    logic [cache_mem_pkg::DATA_WIDTH-1:0] exp_data;
    seq = src_rsp_o[s].seq;
    if (in_flight[s] == 0) begin
      $display("Response for source %0d arrived with nothing in flight", s);
      check_errors++;
    end else begin
      in_flight[s]--;
    end
    if (src_rsp_o[s].is_write !== exp_write[s][seq]) begin
      $display("CHECK FAILED src_rsp_o[%0d].is_write exp %h got %h", s,
               exp_write[s][seq], src_rsp_o[s].is_write);
      check_errors++;
    end else if (!exp_write[s][seq]) begin
      exp_data = read_pattern(exp_addr[s][seq]);
      if (src_rsp_o[s].rdata !== exp_data) begin
        $display("CHECK FAILED src_rsp_o[%0d].rdata exp %h got %h", s, exp_data,
                 src_rsp_o[s].rdata);
        check_errors++;
      end
    end
  endtask

  // Wait for all planned traffic, then the router stage
  task automatic wait_drained();
    do begin
      @(posedge clk_i);
    end while (!traffic_done());
    repeat (2) @(posedge clk_i);
  endtask

  task automatic check_in_flight();
    for (int s = 0; s < NumSrc; s++) begin
      if (in_flight[s] != 0) begin
        $display("Source %0d still has %0d transactions in flight", s, in_flight[s]);
        check_errors++;
      end
    end
  endtask

  ////////////////////
  // Monitor and responder queue
  ////////////////////
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle++;
      for (int s = 0; s < NumSrc; s++) begin
        if (src_rsp_valid_o[s]) begin
          check_response(s);
        end
      end
      fired = src_req_valid_i & src_req_ready_o;
      for (int s = 0; s < NumSrc; s++) begin
        if (fired[s]) begin
          check_request(s);
          exp_addr[s][tb_seq[s]]  = src_req_i[s].addr;
          exp_write[s][tb_seq[s]] = src_req_i[s].is_write;
          tb_seq[s]               = tb_seq[s] + cache_mem_pkg::SEQ_WIDTH'(1);
          sent[s]++;
          in_flight[s]++;
        end
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        delay              = 1 + int'($unsigned($random(seed)) % MaxDelay);
        entry.rsp.id       = mem_req_o.id;
        entry.rsp.is_write = mem_req_o.is_write;
        entry.rsp.rdata    = mem_req_o.is_write ? '0 : read_pattern(mem_req_o.addr);
        entry.due          = 32'(cycle + delay - 1);
        pend_q.push_back(entry);
      end
    end
  end

  ////////////////////
  // Stimulus on the falling edge
  ////////////////////
  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int s = 0; s < NumSrc; s++) begin
        if (fired[s]) begin
          src_req_valid_i[s] = 1'b0;
        end
        if (!src_req_valid_i[s] && (issued[s] < quota[s])
            && (hold_valid || (($random(seed) & 3) == 0))) begin
          new_request(s);
        end
      end
      mem_req_ready_i = ready_always || (($random(seed) & 3) != 0);
      dcache_flush_i  = hold_valid || (($random(seed) & 7) == 0);
      mem_rsp_valid_i = 1'b0;
      if ((pend_q.size() != 0) && (pend_q[0].due <= 32'(cycle))) begin  // Oldest first
        entry           = pend_q.pop_front();
        mem_rsp_i       = entry.rsp;
        mem_rsp_valid_i = 1'b1;
      end
    end
  end

  initial begin
    seed            = 32'ha1af;
    rst_ni          = 1'b0;
    src_req_valid_i = '0;
    src_req_i       = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    dcache_flush_i  = 1'b0;
    hold_valid      = 1'b0;
    ready_always    = 1'b0;
    fired           = '0;
    for (int s = 0; s < NumSrc; s++) begin
      quota[s]     = Phase1Reqs;
      issued[s]    = 0;
      sent[s]      = 0;
      in_flight[s] = 0;
      tb_seq[s]    = '0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    wait_drained();
    // All sources held valid, memory always ready, flush held high
    hold_valid   = 1'b1;
    ready_always = 1'b1;
    for (int s = 0; s < NumSrc; s++) begin
      quota[s] = Phase1Reqs + Phase2Reqs;
    end
    wait_drained();
    check_in_flight();
    $display("Errors: %0d assertion failures, %0d check failures", assert_errors,
             check_errors);
    if ((assert_errors == 0) && (check_errors == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: traffic did not drain within %0d cycles", WatchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- flist.f
common/cache_mem_pkg.sv
mem_arbiter/mem_req_arbiter.sv
mem_arbiter/mem_txn_tracker.sv
mem_arbiter/mem_rsp_router.sv
verilog/cache_mem_subsystem.sv
testbench/cache_mem_subsystem_asserts.sv
testbench/tb_cache_mem_subsystem.sv

//--- Makefile
SIM        := verilator
TOP        := tb_cache_mem_subsystem
FLIST      := flist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
